// ==== filelist.f ====
verilog/soc_bus_pkg.sv
verilog/soc_periph_pkg.sv
verilog/host_bridge.sv
verilog/far_decoder.sv
verilog/timer_regs.sv
verilog/timer_counter.sv
verilog/irq_controller.sv
verilog/system_regs.sv
verilog/soc_periph_top.sv
testbench/tb_soc_periph.sv

// ==== testbench/tb_soc_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
();

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_ACCESSES = 200;
	localparam int UNMAPPED_READS = 16;
	// Host accesses made by the fixed-length tests
	localparam int DEFAULTS_ACCESSES = 1;
	localparam int SOFT_IRQ_ACCESSES = 12;
	localparam int TIMER_ACCESSES = 11;
	localparam int TRANSACTION_COUNT = DEFAULTS_ACCESSES + RANDOM_ACCESSES +
		UNMAPPED_READS + SOFT_IRQ_ACCESSES + TIMER_ACCESSES;
	localparam int TIMER_CYCLES = 2000;
	localparam int HANDSHAKE_LIMIT = 20;
	localparam int HOST_LATENCY = 3;

	logic clock;
	logic reset;
	logic host_req;
	logic host_rw;
	far_addr_t host_address;
	bus_data_t host_wdata;
	logic host_ack;
	bus_data_t host_rdata;
	led_t leds;
	logic o_irq;

	bus_data_t rng_state;
	string current_test;
	int error_count;
	int errors_at_start;
	int tests_run;
	int tests_failed;

	// Register model
	led_t model_leds;
	bus_data_t model_scratch;
	irq_vec_t model_enable;
	logic model_soft;

	soc_periph_top soc_periph_top_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_host_req(host_req),
		.i_host_rw(host_rw),
		.i_host_address(host_address),
		.i_host_wdata(host_wdata),
		.o_host_ack(host_ack),
		.o_host_rdata(host_rdata),
		.o_leds(leds),
		.o_irq(o_irq)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// Watchdog sized from transaction count plus timer run time
	initial begin
		#((TRANSACTION_COUNT * 10 + TIMER_CYCLES) * CLOCK_PERIOD);
		$display("Timeout: the simulation did not finish within the expected time");
		$display("Test FAILED");
		$finish;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic bus_data_t next_random();
		bus_data_t x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Slot in the top nibble, word index above the byte offset
	function automatic far_addr_t reg_address(input slot_t slot, input reg_index_t index);
		return {slot, 19'd0, index, 2'b00};
	endfunction

	task automatic report_mismatch(input string what, input bus_data_t expected,
			input bus_data_t actual);
		$display("FAIL %s (%s): expected 0x%08h, actual 0x%08h",
			current_test, what, expected, actual);
		error_count++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR %s: %s", current_test, what);
		error_count++;
	endtask

	task automatic begin_test(input string name);
		current_test = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("[%s] passed", current_test);
		end else begin
			tests_failed++;
			$display("[%s] failed with %0d errors", current_test,
				error_count - errors_at_start);
		end
	endtask

	// Full four-phase cycle
	// Rising edges from req to ack come back in edges
	task automatic host_access(input logic rw, input far_addr_t address,
			input bus_data_t wdata, output bus_data_t rdata, output int edges);
		int release_edges;
		@(posedge clock);
		host_req <= 1'b1;
		host_rw <= rw;
		host_address <= address;
		host_wdata <= wdata;
		edges = 0;
		do begin
			@(posedge clock);
			edges++;
			@(negedge clock);
		end while (!host_ack && edges < HANDSHAKE_LIMIT);
		if (!host_ack) begin
			report_problem("host acknowledge never arrived");
		end
		rdata = host_rdata;
		@(posedge clock);
		host_req <= 1'b0;
		release_edges = 0;
		do begin
			@(posedge clock);
			release_edges++;
			@(negedge clock);
		end while (host_ack && release_edges < HANDSHAKE_LIMIT);
		if (host_ack) begin
			report_problem("host acknowledge stayed high after request was dropped");
		end
	endtask

	task automatic reg_write(input slot_t slot, input reg_index_t index, input bus_data_t data);
		bus_data_t unused;
		int edges;
		host_access(1'b1, reg_address(slot, index), data, unused, edges);
	endtask

	task automatic reg_read_check(input string what, input slot_t slot,
			input reg_index_t index, input bus_data_t expected);
		bus_data_t rdata;
		int edges;
		host_access(1'b0, reg_address(slot, index), '0, rdata, edges);
		if (rdata !== expected) begin
			report_mismatch(what, expected, rdata);
		end
	endtask

	task automatic wait_for_irq(input logic level, input int max_cycles, output bit reached);
		int n;
		reached = 1'b0;
		for (n = 0; n < max_cycles && !reached; n++) begin
			@(posedge clock);
			@(negedge clock);
			if (o_irq === level) begin
				reached = 1'b1;
			end
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_reset_defaults();
		begin_test("reset_defaults");
		if (leds !== '0) begin
			report_mismatch("leds after reset", 32'd0, bus_data_t'(leds));
		end
		if (o_irq !== 1'b0) begin
			report_mismatch("irq after reset", 32'd0, bus_data_t'(o_irq));
		end
		reg_read_check("device id", SLOT_SYSREG, SYSREG_DEVICE_ID, 32'd6);
		end_test();
	endtask

	task automatic test_random_registers();
		bus_data_t r;
		bus_data_t data;
		bus_data_t rdata;
		bus_data_t expected;
		far_addr_t address;
		int target;
		int edges;
		logic is_write;
		string what;
		begin_test("random_registers");
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			r = next_random();
			data = next_random();
			target = r % 3;
			is_write = r[8];
			case (target)
				0: begin
					address = reg_address(SLOT_SYSREG, SYSREG_LEDS);
					expected = bus_data_t'(model_leds);
					what = "leds";
				end
				1: begin
					address = reg_address(SLOT_SYSREG, SYSREG_SCRATCH);
					expected = model_scratch;
					what = "scratch";
				end
				default: begin
					address = reg_address(SLOT_PLIC, IRQ_REG_ENABLE);
					expected = bus_data_t'(model_enable);
					what = "irq enable";
				end
			endcase
			host_access(is_write, address, data, rdata, edges);
			if (edges != HOST_LATENCY) begin
				report_mismatch("ack latency", HOST_LATENCY, edges);
			end
			if (is_write) begin
				case (target)
					0: model_leds = data[7:0];
					1: model_scratch = data;
					default: model_enable = data[1:0];
				endcase
				if (target == 0 && leds !== model_leds) begin
					report_mismatch("led outputs", bus_data_t'(model_leds), bus_data_t'(leds));
				end
			end else if (rdata !== expected) begin
				report_mismatch(what, expected, rdata);
			end
		end
		end_test();
	endtask

	task automatic test_unmapped_reads();
		slot_t slot;
		reg_index_t index;
		bus_data_t rdata;
		int edges;
		begin_test("unmapped_reads");
		for (int i = 0; i < UNMAPPED_READS; i++) begin
			slot = slot_t'(next_random());
			// Skip the three mapped slots
			while (slot == SLOT_TIMER || slot == SLOT_PLIC || slot == SLOT_SYSREG) begin
				slot = slot + 1'b1;
			end
			index = reg_index_t'(next_random());
			host_access(1'b0, reg_address(slot, index), '0, rdata, edges);
			if (rdata !== '0) begin
				report_mismatch("unmapped read data", 32'd0, rdata);
			end
			if (edges != HOST_LATENCY) begin
				report_mismatch("unmapped ack latency", HOST_LATENCY, edges);
			end
		end
		end_test();
	endtask

	task automatic test_soft_interrupt();
		bit reached;
		begin_test("soft_interrupt");
		reg_write(SLOT_PLIC, IRQ_REG_PENDING, 32'h3);
		model_enable = 2'b10;
		reg_write(SLOT_PLIC, IRQ_REG_ENABLE, bus_data_t'(model_enable));
		model_soft = 1'b1;
		reg_write(SLOT_SYSREG, SYSREG_SOFT_IRQ, 32'd1);
		wait_for_irq(1'b1, 10, reached);
		if (!reached) begin
			report_problem("interrupt did not rise after the software bit was set");
		end
		reg_read_check("soft bit", SLOT_SYSREG, SYSREG_SOFT_IRQ, bus_data_t'(model_soft));
		reg_read_check("pending", SLOT_PLIC, IRQ_REG_PENDING, 32'h2);

		model_soft = 1'b0;
		reg_write(SLOT_SYSREG, SYSREG_SOFT_IRQ, 32'd0);
		reg_write(SLOT_PLIC, IRQ_REG_PENDING, 32'h2);
		wait_for_irq(1'b0, 10, reached);
		if (!reached) begin
			report_problem("interrupt stayed high after the pending bit was cleared");
		end

		// Pending still latches, but the masked output must not move
		model_enable = 2'b00;
		reg_write(SLOT_PLIC, IRQ_REG_ENABLE, 32'd0);
		model_soft = 1'b1;
		reg_write(SLOT_SYSREG, SYSREG_SOFT_IRQ, 32'd1);
		wait_for_irq(1'b1, 20, reached);
		if (reached) begin
			report_problem("interrupt rose although its enable was off");
		end
		reg_read_check("masked pending", SLOT_PLIC, IRQ_REG_PENDING, 32'h2);
		model_soft = 1'b0;
		reg_write(SLOT_SYSREG, SYSREG_SOFT_IRQ, 32'd0);
		reg_write(SLOT_PLIC, IRQ_REG_PENDING, 32'h3);
		end_test();
	endtask

	task automatic test_timer_interrupt();
		bus_data_t compare;
		bus_data_t rdata;
		int edges;
		bit reached;
		begin_test("timer_interrupt");
		compare = 20 + next_random() % 481;
		reg_write(SLOT_PLIC, IRQ_REG_PENDING, 32'h3);
		model_enable = 2'b01;
		reg_write(SLOT_PLIC, IRQ_REG_ENABLE, bus_data_t'(model_enable));
		reg_write(SLOT_TIMER, TIMER_REG_COMPARE, compare);
		reg_write(SLOT_TIMER, TIMER_REG_COUNT, 32'd0);
		reg_write(SLOT_TIMER, TIMER_REG_CONTROL, 32'd1);
		wait_for_irq(1'b1, compare + 10, reached);
		if (!reached) begin
			report_problem("timer interrupt did not rise within compare plus 10 cycles");
		end
		reg_read_check("timer control", SLOT_TIMER, TIMER_REG_CONTROL, 32'h3);
		host_access(1'b0, reg_address(SLOT_TIMER, TIMER_REG_COUNT), '0, rdata, edges);
		if (rdata < compare) begin
			report_mismatch("count below compare", compare, rdata);
		end

		// Clear at the timer first, then at the controller
		reg_write(SLOT_TIMER, TIMER_REG_CONTROL, 32'h2);
		reg_write(SLOT_PLIC, IRQ_REG_PENDING, 32'h1);
		wait_for_irq(1'b0, 10, reached);
		if (!reached) begin
			report_problem("timer interrupt stayed high after both pending bits were cleared");
		end
		reg_read_check("timer control cleared", SLOT_TIMER, TIMER_REG_CONTROL, 32'h0);
		reg_read_check("pending cleared", SLOT_PLIC, IRQ_REG_PENDING, 32'h0);
		end_test();
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		host_req = 1'b0;
		host_rw = 1'b0;
		host_address = '0;
		host_wdata = '0;
		rng_state = 32'd10;
		error_count = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		current_test = "none";
		model_leds = '0;
		model_scratch = '0;
		model_enable = '0;
		model_soft = 1'b0;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);

		test_reset_defaults();
		test_random_registers();
		test_unmapped_reads();
		test_soft_interrupt();
		test_timer_interrupt();

		$display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/soc_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Host port
	input wire i_host_req,
	input wire i_host_rw,
	input wire far_addr_t i_host_address,
	input wire bus_data_t i_host_wdata,
	output logic o_host_ack,
	output bus_data_t o_host_rdata,

	output led_t o_leds,
	output logic o_irq
);

	logic far_request;
	far_req_t far_req;
	far_rsp_t far_rsp;

	logic timer_request;
	logic irq_request;
	logic sysreg_request;
	far_rsp_t timer_rsp;
	far_rsp_t irq_rsp;
	far_rsp_t sysreg_rsp;

	bus_data_t timer_count;
	logic timer_match;
	logic timer_load;
	bus_data_t timer_load_value;
	bus_data_t timer_compare;
	logic timer_irq;
	logic soft_irq;
	irq_vec_t irq_sources;

	assign irq_sources[IRQ_TIMER] = timer_irq;
	assign irq_sources[IRQ_SOFT] = soft_irq;

	// ======================================================================
	// Bridge and far side decode
	// ======================================================================

	host_bridge host_bridge_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_host_req(i_host_req),
		.i_host_rw(i_host_rw),
		.i_host_address(i_host_address),
		.i_host_wdata(i_host_wdata),
		.o_host_ack(o_host_ack),
		.o_host_rdata(o_host_rdata),
		.o_far_request(far_request),
		.o_far_req(far_req),
		.i_far_rsp(far_rsp)
	);

	far_decoder far_decoder_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_far_request(far_request),
		.i_far_req(far_req),
		.o_far_rsp(far_rsp),
		.o_timer_request(timer_request),
		.o_irq_request(irq_request),
		.o_sysreg_request(sysreg_request),
		.i_timer_rsp(timer_rsp),
		.i_irq_rsp(irq_rsp),
		.i_sysreg_rsp(sysreg_rsp)
	);

	// ======================================================================
	// Peripherals
	// ======================================================================

	timer_regs timer_regs_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(timer_request),
		.i_far_req(far_req),
		.o_rsp(timer_rsp),
		.i_count(timer_count),
		.i_match(timer_match),
		.o_load(timer_load),
		.o_load_value(timer_load_value),
		.o_compare(timer_compare),
		.o_irq(timer_irq)
	);

	timer_counter timer_counter_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_load(timer_load),
		.i_load_value(timer_load_value),
		.i_compare(timer_compare),
		.o_count(timer_count),
		.o_match(timer_match)
	);

	irq_controller irq_controller_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(irq_request),
		.i_far_req(far_req),
		.o_rsp(irq_rsp),
		.i_sources(irq_sources),
		.o_irq(o_irq)
	);

	system_regs system_regs_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(sysreg_request),
		.i_far_req(far_req),
		.o_rsp(sysreg_rsp),
		.o_leds(o_leds),
		.o_soft_irq(soft_irq)
	);

endmodule

`default_nettype wire

// ==== verilog/system_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_regs
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire far_req_t i_far_req,
	output far_rsp_t o_rsp,

	output led_t o_leds,
	output logic o_soft_irq
);

	reg_index_t index;
	logic access;
	logic wr;
	logic rsp_ready;
	bus_data_t rsp_rdata;
	bus_data_t scratch;

	assign index = i_far_req.address[INDEX_MSB:INDEX_LSB];
	assign access = i_request && !rsp_ready;
	assign wr = access && i_far_req.rw;
	assign o_rsp = '{rdata: rsp_rdata, ready: rsp_ready};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rsp_ready <= 1'b0;
			o_leds <= '0;
			scratch <= '0;
			o_soft_irq <= 1'b0;
		end else begin
			rsp_ready <= access;
			// Device id is read-only and other offsets are ignored
			if (wr) begin
				case (index)
					SYSREG_LEDS: o_leds <= i_far_req.wdata[LED_COUNT-1:0];
					SYSREG_SCRATCH: scratch <= i_far_req.wdata;
					SYSREG_SOFT_IRQ: o_soft_irq <= i_far_req.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (index)
				SYSREG_DEVICE_ID: rsp_rdata <= DEVICE_ID;
				SYSREG_LEDS: rsp_rdata <= bus_data_t'(o_leds);
				SYSREG_SCRATCH: rsp_rdata <= scratch;
				SYSREG_SOFT_IRQ: rsp_rdata <= bus_data_t'(o_soft_irq);
				default: rsp_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/irq_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_controller
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire far_req_t i_far_req,
	output far_rsp_t o_rsp,

	input wire irq_vec_t i_sources,
	output logic o_irq
);

	reg_index_t index;
	logic access;
	logic wr;
	logic rsp_ready;
	bus_data_t rsp_rdata;
	irq_vec_t wbits;
	irq_vec_t pending;
	irq_vec_t enable;

	assign index = i_far_req.address[INDEX_MSB:INDEX_LSB];
	assign access = i_request && !rsp_ready;
	assign wr = access && i_far_req.rw;
	assign wbits = i_far_req.wdata[IRQ_COUNT-1:0];
	assign o_rsp = '{rdata: rsp_rdata, ready: rsp_ready};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rsp_ready <= 1'b0;
			pending <= '0;
			enable <= '0;
			o_irq <= 1'b0;
		end else begin
			rsp_ready <= access;
			if (wr && index == IRQ_REG_ENABLE) begin
				enable <= wbits;
			end
			// A clear only sticks once the level source is low
			if (wr && index == IRQ_REG_PENDING) begin
				pending <= (pending & ~wbits) | i_sources;
			end else begin
				pending <= pending | i_sources;
			end
			o_irq <= |(pending & enable);
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (index)
				IRQ_REG_PENDING: rsp_rdata <= bus_data_t'(pending);
				IRQ_REG_ENABLE: rsp_rdata <= bus_data_t'(enable);
				default: rsp_rdata <= '0;
			endcase
		end
	end

	a_irq_cause: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_irq |-> $past(|(pending & enable))
	);

endmodule

`default_nettype wire

// ==== verilog/timer_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_counter
	import soc_bus_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// From the register block
	input wire i_load,
	input wire bus_data_t i_load_value,
	input wire bus_data_t i_compare,

	output bus_data_t o_count,
	output logic o_match
);

	// ======================================================================
	// Free-running cycle counter
	// ======================================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_count <= '0;
		end else if (i_load) begin
			o_count <= i_load_value;
		end else begin
			// Wraps at 2^32
			o_count <= o_count + 1'b1;
		end
	end

	// Match in the same cycle the count equals compare
	assign o_match = o_count == i_compare;

endmodule

`default_nettype wire

// ==== verilog/timer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_regs
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire far_req_t i_far_req,
	output far_rsp_t o_rsp,

	// Counter control
	input wire bus_data_t i_count,
	input wire i_match,
	output logic o_load,
	output bus_data_t o_load_value,
	output bus_data_t o_compare,
	output logic o_irq
);

	reg_index_t index;
	logic access;
	logic wr;
	logic rsp_ready;
	bus_data_t rsp_rdata;
	bus_data_t control_word;
	logic enable;
	logic pending;

	assign index = i_far_req.address[INDEX_MSB:INDEX_LSB];
	// Request is still high in the reply cycle, so act only once
	assign access = i_request && !rsp_ready;
	assign wr = access && i_far_req.rw;

	assign o_load = wr && index == TIMER_REG_COUNT;
	assign o_load_value = i_far_req.wdata;
	assign o_irq = pending;
	assign o_rsp = '{rdata: rsp_rdata, ready: rsp_ready};

	always_comb begin
		control_word = '0;
		control_word[TIMER_CTRL_ENABLE] = enable;
		control_word[TIMER_CTRL_PENDING] = pending;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rsp_ready <= 1'b0;
			o_compare <= '0;
			enable <= 1'b0;
			pending <= 1'b0;
		end else begin
			rsp_ready <= access;
			if (wr && index == TIMER_REG_COMPARE) begin
				o_compare <= i_far_req.wdata;
			end
			if (wr && index == TIMER_REG_CONTROL) begin
				enable <= i_far_req.wdata[TIMER_CTRL_ENABLE];
			end
			// Match wins over a clear in the same cycle
			if (i_match && enable) begin
				pending <= 1'b1;
			end else if (wr && index == TIMER_REG_CONTROL &&
					i_far_req.wdata[TIMER_CTRL_PENDING]) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (index)
				TIMER_REG_COUNT: rsp_rdata <= i_count;
				TIMER_REG_COMPARE: rsp_rdata <= o_compare;
				TIMER_REG_CONTROL: rsp_rdata <= control_word;
				default: rsp_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/far_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module far_decoder
	import soc_bus_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// From bridge
	input wire i_far_request,
	input wire far_req_t i_far_req,
	output far_rsp_t o_far_rsp,

	// Peripheral requests and replies
	output logic o_timer_request,
	output logic o_irq_request,
	output logic o_sysreg_request,
	input wire far_rsp_t i_timer_rsp,
	input wire far_rsp_t i_irq_rsp,
	input wire far_rsp_t i_sysreg_rsp
);

	slot_t slot;
	logic timer_sel;
	logic irq_sel;
	logic sysreg_sel;
	logic unmapped_sel;
	logic unmapped_ready;

	assign slot = i_far_req.address[SLOT_MSB:SLOT_LSB];
	assign timer_sel = slot == SLOT_TIMER;
	assign irq_sel = slot == SLOT_PLIC;
	assign sysreg_sel = slot == SLOT_SYSREG;
	assign unmapped_sel = !(timer_sel || irq_sel || sysreg_sel);

	assign o_timer_request = i_far_request && timer_sel;
	assign o_irq_request = i_far_request && irq_sel;
	assign o_sysreg_request = i_far_request && sysreg_sel;

	// Unmapped slots get a one-cycle ready like a peripheral's
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_far_request && unmapped_sel && !unmapped_ready;
		end
	end

	// Reply mux keyed on select
	always_comb begin
		if (timer_sel) begin
			o_far_rsp = i_timer_rsp;
		end else if (irq_sel) begin
			o_far_rsp = i_irq_rsp;
		end else if (sysreg_sel) begin
			o_far_rsp = i_sysreg_rsp;
		end else begin
			o_far_rsp = '{rdata: '0, ready: unmapped_ready};
		end
	end

	a_one_request: assert property (
		@(posedge i_clock) disable iff (i_reset)
		$onehot0({o_timer_request, o_irq_request, o_sysreg_request})
	);

endmodule

`default_nettype wire

// ==== verilog/host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bridge
	import soc_bus_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Host side, four-phase req/ack
	input wire i_host_req,
	input wire i_host_rw,
	input wire far_addr_t i_host_address,
	input wire bus_data_t i_host_wdata,
	output logic o_host_ack,
	output bus_data_t o_host_rdata,

	// Far side
	output logic o_far_request,
	output far_req_t o_far_req,
	input wire far_rsp_t i_far_rsp
);

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		ACK
	} bridge_state_t;

	bridge_state_t state;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_far_request <= 1'b0;
			o_host_ack <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_host_req) begin
						o_far_request <= 1'b1;
						state <= REQUEST;
					end
				end
				REQUEST: begin
					// Hold request until the far side answers
					if (i_far_rsp.ready) begin
						o_far_request <= 1'b0;
						o_host_ack <= 1'b1;
						state <= ACK;
					end
				end
				ACK: begin
					// Host holding req is the back-pressure
					if (!i_host_req) begin
						o_host_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Command capture and read data latch
	always_ff @(posedge i_clock) begin
		if (state == IDLE && i_host_req) begin
			o_far_req.rw <= i_host_rw;
			o_far_req.address <= i_host_address;
			o_far_req.wdata <= i_host_wdata;
		end
		if (state == REQUEST && i_far_rsp.ready) begin
			o_host_rdata <= i_far_rsp.rdata;
		end
	end

	a_no_request_during_ack: assert property (
		@(posedge i_clock) disable iff (i_reset)
		$rose(o_far_request) |-> !o_host_ack
	);

endmodule

`default_nettype wire

// ==== verilog/soc_periph_pkg.sv ====
`default_nettype none

package soc_periph_pkg;
	import soc_bus_pkg::*;

	// Timer word offsets
	localparam reg_index_t TIMER_REG_COUNT = 3'd0;
	localparam reg_index_t TIMER_REG_COMPARE = 3'd1;
	localparam reg_index_t TIMER_REG_CONTROL = 3'd2;

	// Timer control bits
	localparam int TIMER_CTRL_ENABLE = 0;
	// Writing 1 clears pending
	localparam int TIMER_CTRL_PENDING = 1;

	// Interrupt controller word offsets
	localparam reg_index_t IRQ_REG_PENDING = 3'd0;
	localparam reg_index_t IRQ_REG_ENABLE = 3'd1;

	// System register word offsets
	localparam reg_index_t SYSREG_DEVICE_ID = 3'd0;
	localparam reg_index_t SYSREG_LEDS = 3'd1;
	localparam reg_index_t SYSREG_SCRATCH = 3'd2;
	localparam reg_index_t SYSREG_SOFT_IRQ = 3'd3;

	localparam bus_data_t DEVICE_ID = 32'd6;

	// Interrupt sources
	localparam int IRQ_COUNT = 2;
	localparam int IRQ_TIMER = 0;
	localparam int IRQ_SOFT = 1;
	typedef logic [IRQ_COUNT-1:0] irq_vec_t;

	localparam int LED_COUNT = 8;
	typedef logic [LED_COUNT-1:0] led_t;

endpackage

`default_nettype wire

// ==== verilog/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

	// ======================================================================
	// Widths and far address fields
	// ======================================================================

	localparam int DATA_WIDTH = 32;
	localparam int FAR_ADDR_WIDTH = 28;

	// Slot in the top nibble, register word index just above byte offset
	localparam int SLOT_MSB = 27;
	localparam int SLOT_LSB = 24;
	localparam int INDEX_MSB = 4;
	localparam int INDEX_LSB = 2;

	typedef logic [DATA_WIDTH-1:0] bus_data_t;
	typedef logic [FAR_ADDR_WIDTH-1:0] far_addr_t;
	typedef logic [SLOT_MSB-SLOT_LSB:0] slot_t;
	typedef logic [INDEX_MSB-INDEX_LSB:0] reg_index_t;

	// Far side slot map
	localparam slot_t SLOT_TIMER = 4'h5;
	localparam slot_t SLOT_PLIC = 4'h8;
	localparam slot_t SLOT_SYSREG = 4'h9;

	// ======================================================================
	// Far bus request and response
	// ======================================================================

	typedef struct packed {
		logic rw;
		far_addr_t address;
		bus_data_t wdata;
	} far_req_t;

	typedef struct packed {
		bus_data_t rdata;
		logic ready;
	} far_rsp_t;

endpackage

`default_nettype wire
